//--- filelist.f
src/mdio_pkg.sv
src/mdio_regs.sv
src/mdc_gen.sv
src/mdio_frame_build.sv
src/mdio_serializer.sv
src/mdio_master.sv
tb/mdio_phy_model.sv
tb/mdio_master_assert.sv
tb/tb_mdio_master.sv

//--- src/mdc_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MDC clock divider; also marks every mdc falling edge with a one-cycle tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdc_gen (
   input  logic clk,
   input  logic rst,
   output logic mdc,
   output logic fall_tick
);

   import mdio_pkg::*;

   localparam int half_period = mdc_divider / 2;

   logic [$clog2(mdc_divider)-1:0] cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt       <= 1;
         mdc       <= 1'b0;
         fall_tick <= 1'b0;
      end else if (cnt == half_period) begin
         cnt       <= 1;
         mdc       <= ~mdc;
         // Old mdc high means this toggle is the falling edge
         fall_tick <= mdc;
      end else begin
         cnt       <= cnt + 1'b1;
         fall_tick <= 1'b0;
      end
   end

endmodule

//--- src/mdio_frame_build.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Builds the 64-bit management frame and its drive mask from the
// operation, data and address words. Purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdio_frame_build (
   input  mdio_pkg::op_t    op_word,
   input  mdio_pkg::word_t  wr_word,
   input  mdio_pkg::word_t  addr_word,
   output mdio_pkg::frame_t frame,
   output mdio_pkg::frame_t drive_mask,
   output logic             is_read
);

   import mdio_pkg::*;

   // Bits driven by the master on a read: preamble, start, opcode, addresses
   localparam int read_drive_len = frame_len - data_len - 2;

   logic       c45;
   logic [1:0] opcode;
   logic [1:0] start_code;
   logic [1:0] turnaround;
   word_t      payload;

   assign c45        = op_word[op_c45_bit];
   assign opcode     = op_word[op_code_hi:op_code_lo];
   assign is_read    = op_word[op_code_hi];
   assign start_code = c45 ? 2'b00 : 2'b01;

   // On reads the PHY owns the bus from turnaround on, so those bits stay 0
   always_comb begin
      if (is_read) begin
         turnaround = 2'b00;
         payload    = '0;
      end else begin
         turnaround = 2'b10;
         // Clause 45 address cycle carries the register address
         payload    = (c45 && opcode == 2'b00) ? addr_word : wr_word;
      end
   end

   assign frame = {{preamble_len{1'b1}}, start_code, opcode,
                   op_word[prtad_hi:devad_hi+1], op_word[devad_hi:0],
                   turnaround, payload};

   assign drive_mask = is_read ?
                       {{read_drive_len{1'b1}}, {(frame_len-read_drive_len){1'b0}}} :
                       {frame_len{1'b1}};

endmodule

//--- src/mdio_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MDIO bus master top. Software programs the data, address and operation
// words through the register port, then sets start in the control register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdio_master (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            reg_wr_req,
   input  logic [mdio_pkg::reg_width-1:0]  reg_wr_addr,
   input  logic [mdio_pkg::reg_width-1:0]  reg_wr_data,
   input  logic                            reg_rd_req,
   input  logic [mdio_pkg::reg_width-1:0]  reg_rd_addr,
   output logic                            reg_rd_resp,
   output logic [mdio_pkg::reg_width-1:0]  reg_rd_data,
   output logic                            mdc,
   output logic                            mdio_out,
   output logic                            mdio_tri,
   input  logic                            mdio_in
);

   import mdio_pkg::*;

   op_t    op_word;
   word_t  wr_word;
   word_t  addr_word;
   word_t  rd_word;
   frame_t frame;
   frame_t drive_mask;
   logic   is_read;
   logic   running;
   logic   done;
   logic   fall_tick;

   mdio_regs u_mdio_regs (
      .clk         (clk),
      .rst         (rst),
      .reg_wr_req  (reg_wr_req),
      .reg_wr_addr (reg_wr_addr),
      .reg_wr_data (reg_wr_data),
      .reg_rd_req  (reg_rd_req),
      .reg_rd_addr (reg_rd_addr),
      .reg_rd_resp (reg_rd_resp),
      .reg_rd_data (reg_rd_data),
      .rd_word     (rd_word),
      .done        (done),
      .fall_tick   (fall_tick),
      .op_word     (op_word),
      .wr_word     (wr_word),
      .addr_word   (addr_word),
      .running     (running)
   );

   mdc_gen u_mdc_gen (
      .clk       (clk),
      .rst       (rst),
      .mdc       (mdc),
      .fall_tick (fall_tick)
   );

   mdio_frame_build u_mdio_frame_build (
      .op_word    (op_word),
      .wr_word    (wr_word),
      .addr_word  (addr_word),
      .frame      (frame),
      .drive_mask (drive_mask),
      .is_read    (is_read)
   );

   mdio_serializer u_mdio_serializer (
      .clk        (clk),
      .rst        (rst),
      .fall_tick  (fall_tick),
      .running    (running),
      .frame      (frame),
      .drive_mask (drive_mask),
      .is_read    (is_read),
      .mdio_in    (mdio_in),
      .mdio_out   (mdio_out),
      .mdio_tri   (mdio_tri),
      .rd_word    (rd_word),
      .done       (done)
   );

endmodule

//--- src/mdio_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants and types for the MDIO master: register map,
// frame layout, operation word fields and MDC divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mdio_pkg;

   localparam int reg_width    = 32;
   localparam int word_width   = 16;
   localparam int op_width     = 13;

   // One management frame, sent MSB first
   localparam int frame_len    = 64;
   localparam int preamble_len = 32;
   localparam int data_len     = 16;

   // clk cycles per mdc period
   localparam int mdc_divider  = 200;

   localparam logic [reg_width-1:0] reg_base     = 32'h0;
   localparam logic [reg_width-1:0] reg_data_off = 32'h0;
   localparam logic [reg_width-1:0] reg_addr_off = 32'h4;
   localparam logic [reg_width-1:0] reg_op_off   = 32'h8;
   localparam logic [reg_width-1:0] reg_ctrl_off = 32'hc;

   // Operation word: {c45, opcode[1:0], prtad[4:0], devad[4:0]}
   localparam int op_c45_bit   = 12;
   localparam int op_code_hi   = 11;
   localparam int op_code_lo   = 10;
   localparam int prtad_hi     = 9;
   localparam int devad_hi     = 4;

   typedef logic [frame_len-1:0]  frame_t;
   typedef logic [word_width-1:0] word_t;
   typedef logic [op_width-1:0]   op_t;

endpackage

//--- src/mdio_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register front end of the MDIO master. Holds the data, address and
// operation words, the running flag, and answers register reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdio_regs (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            reg_wr_req,
   input  logic [mdio_pkg::reg_width-1:0]  reg_wr_addr,
   input  logic [mdio_pkg::reg_width-1:0]  reg_wr_data,
   input  logic                            reg_rd_req,
   input  logic [mdio_pkg::reg_width-1:0]  reg_rd_addr,
   output logic                            reg_rd_resp,
   output logic [mdio_pkg::reg_width-1:0]  reg_rd_data,
   input  mdio_pkg::word_t                 rd_word,
   input  logic                            done,
   input  logic                            fall_tick,
   output mdio_pkg::op_t                   op_word,
   output mdio_pkg::word_t                 wr_word,
   output mdio_pkg::word_t                 addr_word,
   output logic                            running
);

   import mdio_pkg::*;

   localparam logic [reg_width-1:0] data_addr = reg_base + reg_data_off;
   localparam logic [reg_width-1:0] addr_addr = reg_base + reg_addr_off;
   localparam logic [reg_width-1:0] op_addr   = reg_base + reg_op_off;
   localparam logic [reg_width-1:0] ctrl_addr = reg_base + reg_ctrl_off;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_word   <= '0;
         addr_word <= '0;
         op_word   <= '0;
         running   <= 1'b0;
      end else begin
         // Only drop running on a bit boundary, so software never sees
         // running low while done is still up from the same frame
         if (done && fall_tick)
            running <= 1'b0;

         if (reg_wr_req) begin
            case (reg_wr_addr)
               data_addr: wr_word   <= reg_wr_data[word_width-1:0];
               addr_addr: addr_word <= reg_wr_data[word_width-1:0];
               op_addr:   op_word   <= reg_wr_data[op_width-1:0];
               ctrl_addr: begin
                  if (reg_wr_data[0])
                     running <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         reg_rd_resp <= 1'b0;
      end else begin
         reg_rd_resp <= reg_rd_req &&
                        ((reg_rd_addr == data_addr) || (reg_rd_addr == ctrl_addr));
      end
   end

   // Read data is only meaningful while reg_rd_resp is high
   always_ff @(posedge clk) begin
      if (reg_rd_req) begin
         if (reg_rd_addr == ctrl_addr)
            reg_rd_data <= {{(reg_width-1){1'b0}}, running};
         else
            reg_rd_data <= {{(reg_width-word_width){1'b0}}, rd_word};
      end
   end

endmodule

//--- src/mdio_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shifts a latched frame onto mdio, one bit per mdc falling tick,
// and captures the 16 read bits of read frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdio_serializer (
   input  logic             clk,
   input  logic             rst,
   input  logic             fall_tick,
   input  logic             running,
   input  mdio_pkg::frame_t frame,
   input  mdio_pkg::frame_t drive_mask,
   input  logic             is_read,
   input  logic             mdio_in,
   output logic             mdio_out,
   output logic             mdio_tri,
   output mdio_pkg::word_t  rd_word,
   output logic             done
);

   import mdio_pkg::*;

   localparam int capture_start = frame_len - data_len;

   frame_t                       frame_q;
   frame_t                       mask_q;
   logic                         is_read_q;
   logic                         busy;
   logic                         preidle;
   logic [$clog2(frame_len)-1:0] bit_cnt;
   logic                         start;

   assign start = fall_tick && !busy && !preidle && running;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         preidle  <= 1'b0;
         bit_cnt  <= '0;
         mdio_out <= 1'b0;
         mdio_tri <= 1'b1;
         done     <= 1'b0;
         rd_word  <= '0;
      end else if (fall_tick) begin
         // Release the bus unless a driven bit follows below
         mdio_out <= 1'b0;
         mdio_tri <= 1'b1;
         done     <= 1'b0;
         if (preidle) begin
            // Gives mdio_regs one tick to clear running
            preidle <= 1'b0;
         end else if (busy) begin
            mdio_out <= frame_q[frame_len-1];
            mdio_tri <= ~mask_q[frame_len-1];
            if (is_read_q && bit_cnt >= capture_start)
               rd_word <= {rd_word[data_len-2:0], mdio_in};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == frame_len - 1) begin
               busy    <= 1'b0;
               preidle <= 1'b1;
               done    <= 1'b1;
            end
         end else if (running) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
         end
      end
   end

   // Frame and mask are latched at start so register writes can't disturb
   // a frame already on the wire
   always_ff @(posedge clk) begin
      if (start) begin
         frame_q   <= frame;
         mask_q    <= drive_mask;
         is_read_q <= is_read;
      end else if (fall_tick && busy) begin
         frame_q <= frame_q << 1;
         mask_q  <= mask_q << 1;
      end
   end

endmodule

//--- tb/mdio_master_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions bound into the MDIO master: register read timing,
// bus release while idle and the running flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdio_master_assert (
   input logic                           clk,
   input logic                           rst,
   input logic                           reg_rd_req,
   input logic [mdio_pkg::reg_width-1:0] reg_rd_addr,
   input logic                           reg_rd_resp,
   input logic                           mdio_tri,
   input logic                           running,
   input logic                           done
);

   import mdio_pkg::*;

   logic mapped_rd;

   assign mapped_rd = reg_rd_req && (reg_rd_addr == reg_base + reg_data_off ||
                                     reg_rd_addr == reg_base + reg_ctrl_off);

   rd_resp_follows_req: assert property (@(posedge clk) disable iff (rst)
      mapped_rd |=> reg_rd_resp)
      else $error("reg_rd_resp missing one cycle after a mapped read request");

   rd_resp_only_mapped: assert property (@(posedge clk) disable iff (rst)
      !mapped_rd |=> !reg_rd_resp)
      else $error("reg_rd_resp high without a mapped read request");

   bus_released_idle: assert property (@(posedge clk) disable iff (rst)
      !running |-> mdio_tri)
      else $error("mdio_tri low while running is low");

   // The serializer only finishes frames that software started
   done_while_running: assert property (@(posedge clk) disable iff (rst)
      done |-> running)
      else $error("done high while running is low");

endmodule

//--- tb/mdio_patterns.txt
// kind op_word data_word addr_word phy_value, all hex
// kind 1 = c22 write, 2 = c22 read, 3 = c45 address, 4 = c45 write, 5 = c45 read
1 0420 1234 0000 ffff
1 07e4 a5c3 0000 0000
2 0862 dead 0000 5a3c
2 0a1f 0000 0000 f00f
3 10a1 7777 0c00 0000
4 14a1 8001 0c00 0000
5 1ca1 0000 0c00 3c5a
5 18fe 0000 0000 0001
3 13ff 0000 ffff 0000
1 0400 0000 0000 0000

//--- tb/mdio_phy_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral PHY: records each frame on rising mdc and
// answers read frames with rd_value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mdio_phy_model (
   input  logic             mdc,
   input  logic             mdio_out,
   input  logic             mdio_tri,
   input  mdio_pkg::word_t  rd_value,
   output logic             mdio_in,
   output mdio_pkg::frame_t frame_bits,
   output mdio_pkg::frame_t frame_mask,
   output int               frame_count
);

   import mdio_pkg::*;

   // Frame position of the opcode bit that marks a read
   localparam int read_flag_pos = frame_len - preamble_len - 3;

   // Bits recorded in the current frame, 0 while the bus is idle
   int   bit_idx;
   logic drive_en;
   logic drive_bit;

   initial begin
      bit_idx     = 0;
      drive_en    = 1'b0;
      drive_bit   = 1'b0;
      frame_bits  = '0;
      frame_mask  = '0;
      frame_count = 0;
   end

   // Pull-up on the bus when nobody drives it
   assign mdio_in = drive_en ? drive_bit : 1'b1;

   always @(posedge mdc) begin
      if (bit_idx != 0 || mdio_tri == 1'b0) begin
         frame_bits[frame_len-1-bit_idx] <= ~mdio_tri & mdio_out;
         frame_mask[frame_len-1-bit_idx] <= ~mdio_tri;
         // The master samples on the falling tick that follows, from tick 49 on
         if (frame_bits[read_flag_pos] && bit_idx >= 47 && bit_idx <= 62) begin
            drive_en  <= #1 1'b1;
            drive_bit <= #1 rd_value[62-bit_idx];
         end else begin
            drive_en <= #1 1'b0;
         end
         if (bit_idx == frame_len - 1) begin
            bit_idx     <= 0;
            frame_count <= frame_count + 1;
         end else begin
            bit_idx <= bit_idx + 1;
         end
      end
   end

endmodule

//--- tb/tb_mdio_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the MDIO master. Runs each line of tb/mdio_patterns.txt
// through the register port and checks the frame that the PHY model saw
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_mdio_master;

   import mdio_pkg::*;

   localparam int clk_period  = 4;
   localparam int drive_delay = 1;
   localparam int max_tests   = 32;
   localparam logic [reg_width-1:0] data_reg = reg_base + reg_data_off;
   localparam logic [reg_width-1:0] addr_reg = reg_base + reg_addr_off;
   localparam logic [reg_width-1:0] op_reg   = reg_base + reg_op_off;
   localparam logic [reg_width-1:0] ctrl_reg = reg_base + reg_ctrl_off;

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 reg_wr_req;
   logic [reg_width-1:0] reg_wr_addr;
   logic [reg_width-1:0] reg_wr_data;
   logic                 reg_rd_req;
   logic [reg_width-1:0] reg_rd_addr;
   logic                 reg_rd_resp;
   logic [reg_width-1:0] reg_rd_data;
   logic                 mdc;
   logic                 mdio_out;
   logic                 mdio_tri;
   logic                 mdio_in;
   word_t                phy_value;
   frame_t               phy_frame;
   frame_t               phy_mask;
   int                   phy_frames;
   word_t                last_capture;
   logic [15:0]          pat_mem [0:max_tests*5-1];
   logic                 loaded = 1'b0;
   int                   num_tests = 0;
   int                   error_count = 0;
   int                   pass_count = 0;
   int                   fail_count = 0;

   always #(clk_period/2) clk = ~clk;

   mdio_master u_mdio_master (
      .clk         (clk),
      .rst         (rst),
      .reg_wr_req  (reg_wr_req),
      .reg_wr_addr (reg_wr_addr),
      .reg_wr_data (reg_wr_data),
      .reg_rd_req  (reg_rd_req),
      .reg_rd_addr (reg_rd_addr),
      .reg_rd_resp (reg_rd_resp),
      .reg_rd_data (reg_rd_data),
      .mdc         (mdc),
      .mdio_out    (mdio_out),
      .mdio_tri    (mdio_tri),
      .mdio_in     (mdio_in)
   );

   mdio_phy_model u_mdio_phy_model (
      .mdc         (mdc),
      .mdio_out    (mdio_out),
      .mdio_tri    (mdio_tri),
      .rd_value    (phy_value),
      .mdio_in     (mdio_in),
      .frame_bits  (phy_frame),
      .frame_mask  (phy_mask),
      .frame_count (phy_frames)
   );

   bind mdio_master mdio_master_assert u_mdio_master_assert (
      .clk         (clk),
      .rst         (rst),
      .reg_rd_req  (reg_rd_req),
      .reg_rd_addr (reg_rd_addr),
      .reg_rd_resp (reg_rd_resp),
      .mdio_tri    (mdio_tri),
      .running     (running),
      .done        (done)
   );

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic write_reg(input logic [reg_width-1:0] addr, input logic [reg_width-1:0] data);
      @(posedge clk);
      #drive_delay;
      reg_wr_req  = 1'b1;
      reg_wr_addr = addr;
      reg_wr_data = data;
      @(posedge clk);
      #drive_delay;
      reg_wr_req = 1'b0;
   endtask

   // Gives up after a few cycles, so unmapped offsets come back with got low
   task automatic read_reg(input logic [reg_width-1:0] addr,
                           output logic [reg_width-1:0] data, output logic got);
      int waited;
      @(posedge clk);
      #drive_delay;
      reg_rd_req  = 1'b1;
      reg_rd_addr = addr;
      @(posedge clk);
      #drive_delay;
      reg_rd_req = 1'b0;
      got    = 1'b0;
      data   = '0;
      waited = 0;
      while (!got && waited < 4) begin
         @(negedge clk);
         if (reg_rd_resp) begin
            got  = 1'b1;
            data = reg_rd_data;
         end
         waited++;
      end
   endtask

   function automatic frame_t expected_frame(input logic [15:0] op, input logic [15:0] data,
                                             input logic [15:0] addr);
      logic [1:0] start_code;
      logic [1:0] ta;
      word_t      payload;
      start_code = op[op_c45_bit] ? 2'b00 : 2'b01;
      ta         = 2'b10;
      payload    = data;
      if (op[op_code_hi]) begin
         // The PHY owns turnaround and data on reads
         ta      = 2'b00;
         payload = '0;
      end else if (op[op_c45_bit] && op[op_code_lo] == 1'b0) begin
         payload = addr;
      end
      return {{preamble_len{1'b1}}, start_code, op[op_code_hi:op_code_lo],
              op[9:5], op[4:0], ta, payload};
   endfunction

   function automatic frame_t expected_mask(input logic [15:0] op);
      if (op[op_code_hi])
         return {{46{1'b1}}, 18'b0};
      return '1;
   endfunction

   function automatic string kind_name(input logic [15:0] kind);
      case (kind)
         16'h1:   return "c22 write";
         16'h2:   return "c22 read";
         16'h3:   return "c45 address";
         16'h4:   return "c45 write";
         16'h5:   return "c45 read";
         default: return "unknown kind";
      endcase
   endfunction

   task automatic report_test(input string label, input int errors_before);
      if (error_count == errors_before) begin
         pass_count++;
         $display("test %0d %s: ok", pass_count + fail_count, label);
      end else begin
         fail_count++;
         $display("test %0d %s: %0d errors", pass_count + fail_count, label,
                  error_count - errors_before);
      end
   endtask

   task automatic check_reset_state();
      logic [reg_width-1:0] rdata;
      logic                 got;
      int                   errors_before;
      errors_before = error_count;
      check_value("mdio_tri", mdio_tri, 1'b1);
      check_value("mdc", mdc, 1'b0);
      read_reg(ctrl_reg, rdata, got);
      check_value("reg_rd_resp", got, 1'b1);
      check_value("running", rdata[0], 1'b0);
      read_reg(addr_reg, rdata, got);
      check_value("reg_rd_resp", got, 1'b0);
      read_reg(op_reg, rdata, got);
      check_value("reg_rd_resp", got, 1'b0);
      report_test("reset", errors_before);
   endtask

   task automatic run_pattern(input int n);
      logic [15:0]          op;
      logic [15:0]          wdata;
      logic [15:0]          waddr;
      logic [reg_width-1:0] rdata;
      logic                 got;
      int                   errors_before;
      int                   frames_before;
      op            = pat_mem[n*5+1];
      wdata         = pat_mem[n*5+2];
      waddr         = pat_mem[n*5+3];
      phy_value     = pat_mem[n*5+4];
      errors_before = error_count;
      frames_before = phy_frames;
      write_reg(data_reg, wdata);
      write_reg(addr_reg, waddr);
      write_reg(op_reg, op);
      write_reg(ctrl_reg, 32'h1);
      read_reg(ctrl_reg, rdata, got);
      check_value("reg_rd_resp", got, 1'b1);
      check_value("running", rdata[0], 1'b1);
      do begin
         read_reg(ctrl_reg, rdata, got);
      end while (got && rdata[0]);
      check_value("reg_rd_resp", got, 1'b1);
      check_value("phy frame count", phy_frames, frames_before + 1);
      check_value("mdio frame", phy_frame, expected_frame(op, wdata, waddr));
      check_value("mdio drive mask", phy_mask, expected_mask(op));
      if (op[op_code_hi])
         last_capture = phy_value;
      read_reg(data_reg, rdata, got);
      check_value("reg_rd_resp", got, 1'b1);
      check_value("reg_rd_data", rdata, {16'h0, last_capture});
      report_test(kind_name(pat_mem[n*5]), errors_before);
   endtask

   initial begin
      rst          = 1'b1;
      reg_wr_req   = 1'b0;
      reg_wr_addr  = '0;
      reg_wr_data  = '0;
      reg_rd_req   = 1'b0;
      reg_rd_addr  = '0;
      phy_value    = '0;
      last_capture = '0;
      $readmemh("tb/mdio_patterns.txt", pat_mem);
      while (num_tests < max_tests && !$isunknown(pat_mem[num_tests*5]))
         num_tests++;
      loaded = 1'b1;
      if (num_tests == 0)
         $display("No test patterns could be read from tb/mdio_patterns.txt");
      repeat (16) @(posedge clk);
      #drive_delay;
      rst = 1'b0;
      check_reset_state();
      for (int n = 0; n < num_tests; n++)
         run_pattern(n);
      $display("Summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
      if (fail_count == 0 && num_tests > 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Each frame takes about 66 mdc periods, 80 leaves room for polling
   initial begin
      wait (loaded);
      #(num_tests * 80 * mdc_divider * clk_period + 100 * clk_period);
      $display("Timeout: the frames did not finish in the expected time");
      $display("TESTS FAILED");
      $finish;
   end

endmodule
